/* rtl/rpPkg.sv */
////////////////////////////////////////////////////////////////////////////
// RPxx register file shared definitions
////////////////////////////////////////////////////////////////////////////

package rpPkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////////////////////

   // Host bus data word, full KS-10 width
   typedef logic [35:0] rpData_t;

   // One drive register image
   typedef logic [15:0] rpReg_t;

   // Massbus register address
   typedef logic [4:0]  regAddr_t;

   ////////////////////////////////////////////////////////////////////////////
   // Register addresses
   ////////////////////////////////////////////////////////////////////////////

   // Desired sector and track
   localparam regAddr_t addrRPDA = 5'd5;
   // Offset
   localparam regAddr_t addrRPOF = 5'd9;
   // Desired cylinder
   localparam regAddr_t addrRPDC = 5'd10;

   ////////////////////////////////////////////////////////////////////////////
   // Field positions
   ////////////////////////////////////////////////////////////////////////////

   // RPOF single bits
   localparam logic [3:0] bitF16  = 4'd12;
   localparam logic [3:0] bitECI  = 4'd11;
   localparam logic [3:0] bitHCI  = 4'd10;
   localparam logic [3:0] bitOFD  = 4'd7;
   // RPOF head offset
   localparam logic [3:0] ofsHi   = 4'd6;
   localparam logic [3:0] ofsLo   = 4'd0;

   // RPDA track and sector
   localparam logic [3:0] trackHi = 4'd12;
   localparam logic [3:0] trackLo = 4'd8;
   localparam logic [3:0] sectHi  = 4'd5;
   localparam logic [3:0] sectLo  = 4'd0;

   // RPDC cylinder
   localparam logic [3:0] cylHi   = 4'd9;
   localparam logic [3:0] cylLo   = 4'd0;

   // Decoded bus write, at most one strobe set
   typedef struct packed {
      logic    rpofWrite;
      logic    rpdaWrite;
      logic    rpdcWrite;
      rpData_t data;
   } rpWrite_t;

endpackage

/* rtl/rpBusDecode.sv */
////////////////////////////////////////////////////////////////////////////
// Register bus decoder
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpBusDecode
   import rpPkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     wrStrobe,
   input  logic     rdStrobe,
   input  regAddr_t busAddr,
   input  rpData_t  busData,
   output rpWrite_t busWr,
   output logic     readSel,
   output regAddr_t readAddr,
   output logic     nxr
);

   // Address hits
   logic hitOF;
   logic hitDA;
   logic hitDC;
   logic hitAny;

   // Registered strobes and payload
   logic [2:0] wrSel;
   rpData_t    wrData;

   assign hitOF  = (busAddr == addrRPOF);
   assign hitDA  = (busAddr == addrRPDA);
   assign hitDC  = (busAddr == addrRPDC);
   assign hitAny = hitOF | hitDA | hitDC;

   // Control side, one cycle pulses
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wrSel   <= '0;
         readSel <= 1'b0;
         nxr     <= 1'b0;
      end
      else
      begin
         wrSel   <= {wrStrobe & hitOF, wrStrobe & hitDA, wrStrobe & hitDC};
         // Bad addresses still complete, mux returns zero
         readSel <= rdStrobe;
         nxr     <= (wrStrobe | rdStrobe) & ~hitAny;
      end
   end

   // Data and address captured with their strobe
   always_ff @(posedge clk)
   begin
      if (wrStrobe)
         wrData <= busData;
      if (rdStrobe)
         readAddr <= busAddr;
   end

   assign busWr = '{rpofWrite: wrSel[2], rpdaWrite: wrSel[1],
                    rpdcWrite: wrSel[0], data: wrData};

   // One register written per bus cycle
   assert property (@(posedge clk) disable iff (rst)
      $onehot0({busWr.rpofWrite, busWr.rpdaWrite, busWr.rpdcWrite}));

   // Host never issues both strobes together
   assert property (@(posedge clk) disable iff (rst) !(wrStrobe && rdStrobe));

endmodule

/* rtl/rpof.sv */
////////////////////////////////////////////////////////////////////////////
// RPOF offset register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpof
   import rpPkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     clr,
   input  rpWrite_t busWr,
   output rpReg_t   rpOF
);

   // Format 16 bit
   logic       ofF16;
   // Error correction inhibit
   logic       ofECI;
   // Header compare inhibit
   logic       ofHCI;
   // Offset direction
   logic       ofOFD;
   // Head offset magnitude
   logic [6:0] ofOFS;

   ////////////////////////////////////////////////////////////////////////////
   // Field flops
   ////////////////////////////////////////////////////////////////////////////

   // Fields are storage only, drive mechanics not modelled
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ofF16 <= 1'b0;
         ofECI <= 1'b0;
         ofHCI <= 1'b0;
         ofOFD <= 1'b0;
         ofOFS <= '0;
      end
      else if (clr)
      begin
         // Controller clear acts like reset
         ofF16 <= 1'b0;
         ofECI <= 1'b0;
         ofHCI <= 1'b0;
         ofOFD <= 1'b0;
         ofOFS <= '0;
      end
      else if (busWr.rpofWrite)
      begin
         ofF16 <= busWr.data[bitF16];
         ofECI <= busWr.data[bitECI];
         ofHCI <= busWr.data[bitHCI];
         ofOFD <= busWr.data[bitOFD];
         ofOFS <= busWr.data[ofsHi:ofsLo];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Register image
   ////////////////////////////////////////////////////////////////////////////

   // Unused bits read as zero
   always_comb
   begin
      rpOF              = '0;
      rpOF[bitF16]      = ofF16;
      rpOF[bitECI]      = ofECI;
      rpOF[bitHCI]      = ofHCI;
      rpOF[bitOFD]      = ofOFD;
      rpOF[ofsHi:ofsLo] = ofOFS;
   end

endmodule

/* rtl/rpAddrCounter.sv */
////////////////////////////////////////////////////////////////////////////
// RPDA and RPDC disk address counter
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpAddrCounter
   import rpPkg::*;
#(
   parameter int numSect  = 20,
   parameter int numTrack = 19,
   parameter int numCyl   = 815
)
(
   input  logic     clk,
   input  logic     rst,
   input  logic     clr,
   input  rpWrite_t busWr,
   input  logic     sectDone,
   output rpReg_t   rpDA,
   output rpReg_t   rpDC,
   output logic     aoe
);

   // Address fields
   logic [sectHi-sectLo:0]   sect;
   logic [trackHi-trackLo:0] track;
   logic [cylHi-cylLo:0]     cyl;

   // At or past the last value of each field
   logic sectWrap;
   logic trackWrap;
   logic cylWrap;

   assign sectWrap  = int'(sect)  >= numSect - 1;
   assign trackWrap = int'(track) >= numTrack - 1;
   assign cylWrap   = int'(cyl)   >= numCyl - 1;

   ////////////////////////////////////////////////////////////////////////////
   // RPDA, sector and track
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         sect  <= '0;
         track <= '0;
      end
      else if (clr)
      begin
         sect  <= '0;
         track <= '0;
      end
      else if (busWr.rpdaWrite)
      begin
         sect  <= busWr.data[sectHi:sectLo];
         track <= busWr.data[trackHi:trackLo];
      end
      else if (sectDone)
      begin
         if (!sectWrap)
            sect <= sect + 1'b1;
         else
         begin
            // Sector wraps into the track
            sect <= '0;
            if (trackWrap)
               track <= '0;
            else
               track <= track + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // RPDC and address overflow
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         cyl <= '0;
         aoe <= 1'b0;
      end
      else if (clr)
      begin
         cyl <= '0;
         aoe <= 1'b0;
      end
      else if (busWr.rpdcWrite)
      begin
         // New cylinder also drops the overflow
         cyl <= busWr.data[cylHi:cylLo];
         aoe <= 1'b0;
      end
      else if (sectDone && sectWrap && trackWrap)
      begin
         if (cylWrap)
         begin
            // Ran off the last cylinder
            cyl <= '0;
            aoe <= 1'b1;
         end
         else
            cyl <= cyl + 1'b1;
      end
   end

   // Images with unused bits zero
   always_comb
   begin
      rpDA                  = '0;
      rpDA[trackHi:trackLo] = track;
      rpDA[sectHi:sectLo]   = sect;
      rpDC                  = '0;
      rpDC[cylHi:cylLo]     = cyl;
   end

   // Overflow is only ever caused by a sector advance
   assert property (@(posedge clk) disable iff (rst) $rose(aoe) |-> $past(sectDone));

endmodule

/* rtl/rpReadMux.sv */
////////////////////////////////////////////////////////////////////////////
// Register read multiplexer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpReadMux
   import rpPkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     readSel,
   input  regAddr_t readAddr,
   input  rpReg_t   rpOF,
   input  rpReg_t   rpDA,
   input  rpReg_t   rpDC,
   output rpReg_t   rdData,
   output logic     rdDone
);

   // Image chosen by the latched address
   rpReg_t rdImage;

   // Unknown addresses fall through to zero
   always_comb
   begin
      case (readAddr)
         addrRPOF: rdImage = rpOF;
         addrRPDA: rdImage = rpDA;
         addrRPDC: rdImage = rpDC;
         default:  rdImage = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Output stage
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rdData <= '0;
         rdDone <= 1'b0;
      end
      else
      begin
         rdDone <= readSel;
         // Data holds until the next read
         if (readSel)
            rdData <= rdImage;
      end
   end

endmodule

/* rtl/rpRegs.sv */
////////////////////////////////////////////////////////////////////////////
// RPxx drive register file top
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpRegs
   import rpPkg::*;
#(
   // Geometry defaults to an RP06
   parameter int numSect  = 20,
   parameter int numTrack = 19,
   parameter int numCyl   = 815
)
(
   input  logic     clk,
   input  logic     rst,
   input  logic     clr,
   input  logic     wrStrobe,
   input  logic     rdStrobe,
   input  regAddr_t busAddr,
   input  rpData_t  busData,
   input  logic     sectDone,
   output rpReg_t   rdData,
   output logic     rdDone,
   output logic     nxr,
   output logic     aoe
);

   // Decoded bus
   rpWrite_t busWr;
   logic     readSel;
   regAddr_t readAddr;

   // Register images
   rpReg_t   rpOF;
   rpReg_t   rpDA;
   rpReg_t   rpDC;

   rpBusDecode decodeInst (
      .clk      (clk),
      .rst      (rst),
      .wrStrobe (wrStrobe),
      .rdStrobe (rdStrobe),
      .busAddr  (busAddr),
      .busData  (busData),
      .busWr    (busWr),
      .readSel  (readSel),
      .readAddr (readAddr),
      .nxr      (nxr)
   );

   rpof offsetInst (
      .clk   (clk),
      .rst   (rst),
      .clr   (clr),
      .busWr (busWr),
      .rpOF  (rpOF)
   );

   rpAddrCounter #(
      .numSect  (numSect),
      .numTrack (numTrack),
      .numCyl   (numCyl)
   ) addrInst (
      .clk      (clk),
      .rst      (rst),
      .clr      (clr),
      .busWr    (busWr),
      .sectDone (sectDone),
      .rpDA     (rpDA),
      .rpDC     (rpDC),
      .aoe      (aoe)
   );

   rpReadMux readInst (
      .clk      (clk),
      .rst      (rst),
      .readSel  (readSel),
      .readAddr (readAddr),
      .rpOF     (rpOF),
      .rpDA     (rpDA),
      .rpDC     (rpDC),
      .rdData   (rdData),
      .rdDone   (rdDone)
   );

endmodule

/* dv/rpModel.svh */
////////////////////////////////////////////////////////////////////////////
// RPxx register reference model
////////////////////////////////////////////////////////////////////////////

`ifndef RP_MODEL_SVH
`define RP_MODEL_SVH

// Expected register contents
rpReg_t mOF;
int     mSect;
int     mTrack;
int     mCyl;
logic   mAoe;

// Reset and controller clear look the same
function automatic void clearModel();
   mOF    = '0;
   mSect  = 0;
   mTrack = 0;
   mCyl   = 0;
   mAoe   = 1'b0;
endfunction

// Only RPDA, RPOF and RPDC exist
function automatic bit knownAddr(regAddr_t addr);
   return (addr == 5'd5) || (addr == 5'd9) || (addr == 5'd10);
endfunction

// Bus write, fields taken at their documented bit positions
function automatic void storeWrite(regAddr_t addr, rpData_t data);
   if (addr == 5'd9)
      // F16, ECI, HCI, OFD and offset survive
      mOF = data[15:0] & 16'h1CFF;
   else if (addr == 5'd5)
   begin
      mSect  = int'(data[5:0]);
      mTrack = int'(data[12:8]);
   end
   else if (addr == 5'd10)
   begin
      mCyl = int'(data[9:0]);
      mAoe = 1'b0;
   end
endfunction

// One sector done, anything at or past its limit wraps
function automatic void stepSector();
   if (mSect < geoSect - 1)
      mSect = mSect + 1;
   else
   begin
      mSect = 0;
      if (mTrack < geoTrack - 1)
         mTrack = mTrack + 1;
      else
      begin
         mTrack = 0;
         if (mCyl < geoCyl - 1)
            mCyl = mCyl + 1;
         else
         begin
            mCyl = 0;
            mAoe = 1'b1;
         end
      end
   end
endfunction

// 16-bit image a read should return
function automatic rpReg_t expectRead(regAddr_t addr);
   rpReg_t img;
   img = '0;
   if (addr == 5'd9)
      img = mOF;
   else if (addr == 5'd5)
   begin
      img[12:8] = 5'(mTrack);
      img[5:0]  = 6'(mSect);
   end
   else if (addr == 5'd10)
      img[9:0] = 10'(mCyl);
   return img;
endfunction

`endif

/* dv/rpTb.sv */
////////////////////////////////////////////////////////////////////////////
// RPxx register file testbench
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpTb
   import rpPkg::*;
();

   // RP06 geometry, same as the DUT defaults
   localparam int geoSect  = 20;
   localparam int geoTrack = 19;
   localparam int geoCyl   = 815;

   localparam int clkHalf   = 10;
   localparam int numRounds = 16;
   localparam int maxRun    = 24;

   // Worst case bus operations over all tests, three cycles each
   localparam int opBudget      = numRounds * (2 + 4 + 4 + maxRun + 5) + 64;
   localparam int watchdogCycle = opBudget * 3 + 200;

   logic     clk;
   logic     rst;
   logic     clr;
   logic     wrStrobe;
   logic     rdStrobe;
   regAddr_t busAddr;
   rpData_t  busData;
   logic     sectDone;
   rpReg_t   rdData;
   logic     rdDone;
   logic     nxr;
   logic     aoe;

   integer seed = 32'h6e2d;
   int     errCount;
   int     checkCount;
   int     testCount;
   int     errAtStart;

   `include "rpModel.svh"

   rpRegs #(
      .numSect  (geoSect),
      .numTrack (geoTrack),
      .numCyl   (geoCyl)
   ) dut_i (
      .clk      (clk),
      .rst      (rst),
      .clr      (clr),
      .wrStrobe (wrStrobe),
      .rdStrobe (rdStrobe),
      .busAddr  (busAddr),
      .busData  (busData),
      .sectDone (sectDone),
      .rdData   (rdData),
      .rdDone   (rdDone),
      .nxr      (nxr),
      .aoe      (aoe)
   );

   always #clkHalf clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Random helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic int randBelow(int n);
      logic [31:0] r;
      r = $random(seed);
      return int'(r % 32'(n));
   endfunction

   function automatic rpData_t randData();
      logic [63:0] r;
      r = {$random(seed), $random(seed)};
      return r[35:0];
   endfunction

   function automatic regAddr_t randBadAddr();
      regAddr_t a;
      a = 5'(randBelow(32));
      while (knownAddr(a))
         a = 5'(randBelow(32));
      return a;
   endfunction

   // Mostly at or just below the limit, sometimes past it
   function automatic int nearLimit(int limit, int span);
      int pick;
      pick = randBelow(4);
      case (pick)
         0:       return limit - 1;
         1:       return limit - 2;
         2:       return randBelow(span);
         default: return randBelow(limit);
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Checking and bus tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic compareVal(input logic [35:0] got, input logic [35:0] exp,
                             input string what);
      checkCount++;
      if (got !== exp)
      begin
         errCount++;
         $display("mismatch at %0d ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic endTest(input string name);
      testCount++;
      $display("test %-22s %s, %0d errors", name,
               (errCount == errAtStart) ? "ok" : "failed", errCount - errAtStart);
      errAtStart = errCount;
   endtask

   task automatic applyReset();
      rst = 1'b1;
      repeat (5) @(negedge clk);
      rst = 1'b0;
      clearModel();
   endtask

   // Called on a falling edge, returns three cycles later
   task automatic busWrite(input regAddr_t addr, input rpData_t data);
      wrStrobe = 1'b1;
      busAddr  = addr;
      busData  = data;
      @(negedge clk);
      wrStrobe = 1'b0;
      compareVal(36'(nxr), 36'(!knownAddr(addr)), $sformatf("nxr after write to %0d", addr));
      @(negedge clk);
      compareVal(36'(nxr), 36'(0), "nxr longer than one cycle");
      @(negedge clk);
      storeWrite(addr, data);
   endtask

   task automatic busRead(input regAddr_t addr, output rpReg_t data);
      int edges;
      bit seen;
      edges    = 0;
      seen     = 1'b0;
      rdStrobe = 1'b1;
      busAddr  = addr;
      // Count edges until rdDone shows up
      while (!seen && edges < 4)
      begin
         @(negedge clk);
         rdStrobe = 1'b0;
         edges++;
         if (edges == 1)
            compareVal(36'(nxr), 36'(!knownAddr(addr)),
                       $sformatf("nxr after read of %0d", addr));
         else if (edges == 2)
            compareVal(36'(nxr), 36'(0), "nxr longer than one cycle");
         if (rdDone)
            seen = 1'b1;
      end
      data = rdData;
      if (!seen)
      begin
         errCount++;
         $display("read of register %0d at %0d ns never raised rdDone", addr, $time);
      end
      else
         compareVal(36'(edges), 36'(2), "edges from read strobe to rdDone");
      while (edges < 3)
      begin
         @(negedge clk);
         edges++;
         compareVal(36'(rdDone), 36'(0), "rdDone longer than one cycle");
      end
   endtask

   task automatic readCheck(input regAddr_t addr, input string what);
      rpReg_t got;
      busRead(addr, got);
      compareVal(36'(got), 36'(expectRead(addr)), what);
   endtask

   task automatic readAll(input string what);
      readCheck(addrRPOF, {what, " RPOF"});
      readCheck(addrRPDA, {what, " RPDA"});
      readCheck(addrRPDC, {what, " RPDC"});
   endtask

   task automatic pulseSector();
      sectDone = 1'b1;
      @(negedge clk);
      sectDone = 1'b0;
      stepSector();
      compareVal(36'(aoe), 36'(mAoe), "aoe after sector pulse");
   endtask

   task automatic clearCycle();
      clr = 1'b1;
      @(negedge clk);
      clr = 1'b0;
      clearModel();
   endtask

   // Park the address at the very last sector of the disk
   task automatic loadLastSector();
      rpData_t data;
      data       = randData();
      data[12:8] = 5'(geoTrack - 1);
      data[5:0]  = 6'(geoSect - 1);
      busWrite(addrRPDA, data);
      data       = randData();
      data[9:0]  = 10'(geoCyl - 1);
      busWrite(addrRPDC, data);
   endtask

   // Overflow off the last cylinder, then leave all three registers nonzero
   task automatic dirtyWithOverflow();
      rpData_t data;
      loadLastSector();
      pulseSector();
      data       = randData();
      data[12:8] = 5'(geoTrack - 1);
      data[5:0]  = 6'(geoSect - 1);
      busWrite(addrRPDA, data);
      // Cylinder steps off zero, overflow stays set
      pulseSector();
      data      = randData();
      data[5:0] = 6'(1 + randBelow(geoSect - 1));
      busWrite(addrRPDA, data);
      busWrite(addrRPOF, randData());
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic offsetTest();
      for (int r = 0; r < numRounds; r++)
      begin
         busWrite(addrRPOF, randData());
         readCheck(addrRPOF, $sformatf("RPOF read-back %0d", r));
      end
      endTest("offset register");
   endtask

   task automatic diskAddrTest();
      for (int r = 0; r < numRounds; r++)
      begin
         busWrite(addrRPDA, randData());
         busWrite(addrRPDC, randData());
         readCheck(addrRPDA, $sformatf("RPDA read-back %0d", r));
         readCheck(addrRPDC, $sformatf("RPDC read-back %0d", r));
      end
      endTest("disk address registers");
   endtask

   task automatic stepTest();
      rpData_t data;
      int      run;
      for (int r = 0; r < numRounds; r++)
      begin
         data       = randData();
         data[12:8] = 5'(nearLimit(geoTrack, 32));
         data[5:0]  = 6'(nearLimit(geoSect, 64));
         busWrite(addrRPDA, data);
         data       = randData();
         data[9:0]  = 10'(nearLimit(geoCyl, 1024));
         busWrite(addrRPDC, data);
         run = 1 + randBelow(maxRun);
         for (int p = 0; p < run; p++)
            pulseSector();
         readCheck(addrRPDA, $sformatf("RPDA after %0d sectors", run));
         readCheck(addrRPDC, $sformatf("RPDC after %0d sectors", run));
      end
      endTest("sector stepping");
   endtask

   task automatic clearTest();
      // Overflow with every register dirty, then controller clear
      dirtyWithOverflow();
      compareVal(36'(aoe), 36'(1), "aoe after last cylinder");
      clearCycle();
      @(negedge clk);
      compareVal(36'(aoe), 36'(0), "aoe after clr");
      readAll("after clr");
      // Overflow again, cleared by RPDC write
      loadLastSector();
      pulseSector();
      compareVal(36'(aoe), 36'(1), "aoe after second wrap");
      busWrite(addrRPDC, randData());
      compareVal(36'(aoe), 36'(mAoe), "aoe after RPDC write");
      readAll("after RPDC write");
      endTest("clear and overflow");
   endtask

   task automatic badAddrTest();
      regAddr_t bad;
      for (int r = 0; r < numRounds; r++)
      begin
         bad = randBadAddr();
         busWrite(bad, randData());
         readCheck(bad, $sformatf("read of missing register %0d", bad));
         readAll($sformatf("after access to %0d", bad));
      end
      endTest("non-existent registers");
   endtask

   task automatic resetTest();
      // Dirty every register and set the overflow first
      dirtyWithOverflow();
      // Bad read strobe held through the whole reset
      rdStrobe = 1'b1;
      busAddr  = randBadAddr();
      applyReset();
      rdStrobe = 1'b0;
      compareVal(36'(aoe), 36'(0), "aoe after reset");
      compareVal(36'(nxr), 36'(0), "nxr after reset");
      compareVal(36'(rdDone), 36'(0), "rdDone after reset");
      compareVal(36'(rdData), 36'(0), "rdData after reset");
      readAll("after reset");
      endTest("reset state");
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence and watchdog
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      clk        = 1'b0;
      rst        = 1'b1;
      clr        = 1'b0;
      wrStrobe   = 1'b0;
      rdStrobe   = 1'b0;
      busAddr    = '0;
      busData    = '0;
      sectDone   = 1'b0;
      errCount   = 0;
      checkCount = 0;
      testCount  = 0;
      errAtStart = 0;
      applyReset();
      offsetTest();
      diskAddrTest();
      stepTest();
      clearTest();
      badAddrTest();
      resetTest();
      $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
      if (errCount == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   // Budget scales with the operation count
   initial
   begin
      #(watchdogCycle * 2 * clkHalf);
      $display("watchdog expired after %0d cycles, test sequence did not finish",
               watchdogCycle);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

/* list.f */
+incdir+dv
rtl/rpPkg.sv
rtl/rpBusDecode.sv
rtl/rpof.sv
rtl/rpAddrCounter.sv
rtl/rpReadMux.sv
rtl/rpRegs.sv
dv/rpTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the RP register file testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f list.f --top-module rpTb -Mdir "$buildDir" -o rpTbSim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$buildDir/rpTbSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
   echo "simulation exited with status $simStatus"
   exit 1
fi

if grep -q "SOME TESTS FAILED" "$logFile"; then
   echo "testbench reported failures, see $logFile"
   exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$logFile"; then
   echo "no pass message found in $logFile"
   exit 1
fi
echo "simulation passed"
exit 0
